// ==== rtl/root_counter_pkg.sv ====
package root_counter_pkg;

   // register and counter width
   localparam int WORD_W = 16;

   // host port address and byte lanes
   localparam int ADDR_W = 2;
   localparam int BEN_W  = 2;

   // mode bits kept in the register, the rest come from status
   localparam int MODE_LIVE_W = 10;

   // divide-by-eight tick source
   localparam int PRESCALE_W = 3;

   // interrupt pulse length is 2**PULSE_W cycles
   localparam int PULSE_W = 4;

   typedef logic [WORD_W-1:0] word_t;

   localparam logic [ADDR_W-1:0] ADDR_VALUE  = 2'd0;
   localparam logic [ADDR_W-1:0] ADDR_MODE   = 2'd1;
   localparam logic [ADDR_W-1:0] ADDR_TARGET = 2'd2;

   localparam word_t COUNT_MAX = 16'hFFFF;

   // counter mode word, msb first
   typedef struct packed {
      logic [2:0] reserved;
      logic       reached_max;
      logic       reached_target;
      logic       irq_n;
      logic [1:0] clk_src;
      logic       irq_toggle;
      logic       irq_repeat;
      logic       irq_on_max;
      logic       irq_on_target;
      logic       reset_at_target;
      logic [1:0] sync_mode;
      logic       sync_en;
   } mode_fields_t;

   // same word seen as bus data or as decoded fields
   typedef union packed {
      word_t        raw;
      mode_fields_t f;
   } mode_word_u;

endpackage

// ==== rtl/root_counter_regs.sv ====
`timescale 1ns/1ps

module root_counter_regs (
   input  logic                               sys_clk,
   input  logic                               rst,
   input  logic                               req_i,
   input  logic                               we_i,
   input  logic [root_counter_pkg::ADDR_W-1:0] addr_i,
   input  root_counter_pkg::word_t            wdata_i,
   input  logic [root_counter_pkg::BEN_W-1:0]  ben_i,
   input  root_counter_pkg::word_t            value_i,
   input  logic                               irq_n_i,
   input  logic                               reached_target_i,
   input  logic                               reached_max_i,
   output logic                               ack_o,
   output root_counter_pkg::word_t            rdata_o,
   output logic                               value_load_o,
   output root_counter_pkg::word_t            wdata_o,
   output logic [root_counter_pkg::BEN_W-1:0]  ben_o,
   output logic                               mode_write_o,
   output logic                               status_clr_o,
   output root_counter_pkg::word_t            target_o,
   output root_counter_pkg::mode_word_u       mode_o
);

   logic                         access;
   logic                         ack_q;
   logic                         mode_write_q;
   root_counter_pkg::mode_word_u mode_q;
   root_counter_pkg::mode_word_u rd_mode;
   root_counter_pkg::word_t      target_q;
   root_counter_pkg::word_t      rd_word;
   root_counter_pkg::word_t      rdata_q;

   // one access per request, on the edge that raises ack
   assign access = req_i & ~ack_q;

   // value load goes straight to the core so it lands with ack
   assign value_load_o = access & we_i & (addr_i == root_counter_pkg::ADDR_VALUE);
   assign status_clr_o = access & ~we_i & (addr_i == root_counter_pkg::ADDR_MODE);
   assign wdata_o      = wdata_i;
   assign ben_o        = ben_i;

   always_ff @(posedge sys_clk or posedge rst) begin
      if (rst) begin
         ack_q        <= 1'b0;
         mode_write_q <= 1'b0;
         mode_q       <= '0;
         target_q     <= '0;
      end else begin
         // ack follows req by one cycle in both directions
         ack_q        <= req_i;
         mode_write_q <= access & we_i & (addr_i == root_counter_pkg::ADDR_MODE);
         if (access && we_i && (addr_i == root_counter_pkg::ADDR_MODE)) begin
            if (ben_i[0]) mode_q.raw[7:0] <= wdata_i[7:0];
            if (ben_i[1]) begin
               mode_q.raw[root_counter_pkg::MODE_LIVE_W-1:8] <=
                  wdata_i[root_counter_pkg::MODE_LIVE_W-1:8];
            end
         end
         if (access && we_i && (addr_i == root_counter_pkg::ADDR_TARGET)) begin
            if (ben_i[0]) target_q[7:0] <= wdata_i[7:0];
            if (ben_i[1]) target_q[15:8] <= wdata_i[15:8];
         end
      end
   end

   // status bits overlay the stored mode on readback
   always_comb begin
      rd_mode                  = mode_q;
      rd_mode.f.irq_n          = irq_n_i;
      rd_mode.f.reached_target = reached_target_i;
      rd_mode.f.reached_max    = reached_max_i;
      case (addr_i)
         root_counter_pkg::ADDR_VALUE:  rd_word = value_i;
         root_counter_pkg::ADDR_MODE:   rd_word = rd_mode.raw;
         root_counter_pkg::ADDR_TARGET: rd_word = target_q;
         default:                       rd_word = '0;
      endcase
   end

   // read data held for the whole ack phase
   always_ff @(posedge sys_clk) begin
      if (access) rdata_q <= rd_word;
   end

   assign ack_o        = ack_q;
   assign rdata_o      = rdata_q;
   assign mode_write_o = mode_write_q;
   assign target_o     = target_q;
   assign mode_o       = mode_q;

endmodule

// ==== rtl/root_counter_core.sv ====
`timescale 1ns/1ps

module root_counter_core (
   input  logic                               sys_clk,
   input  logic                               rst,
   input  logic                               value_load_i,
   input  root_counter_pkg::word_t            wdata_i,
   input  logic [root_counter_pkg::BEN_W-1:0]  ben_i,
   input  logic                               mode_write_i,
   input  root_counter_pkg::mode_word_u       mode_i,
   input  root_counter_pkg::word_t            target_i,
   output root_counter_pkg::word_t            value_o,
   output logic                               hit_target_o,
   output logic                               hit_max_o
);

   logic [root_counter_pkg::PRESCALE_W-1:0] prescale_q;
   root_counter_pkg::word_t                 value_q;
   logic                                    tick;
   logic                                    count_en;
   logic                                    stopped;
   logic                                    wrap_at_target;

   // free running divider, never reset by mode writes
   always_ff @(posedge sys_clk or posedge rst) begin
      if (rst) begin
         prescale_q <= '0;
      end else begin
         prescale_q <= prescale_q + 1'b1;
      end
   end

   // clk_src 0 or 2 ticks every cycle, 1 or 3 every eighth
   assign tick = mode_i.f.clk_src[0] ? (prescale_q == '1) : 1'b1;

   // host writes take the counter for that cycle
   assign count_en = tick & ~value_load_i & ~mode_write_i;

   // sync modes 0 and 3 stop the counter, 1 and 2 run free
   assign stopped = mode_i.f.sync_en &
                    (mode_i.f.sync_mode[0] == mode_i.f.sync_mode[1]);

   assign wrap_at_target = mode_i.f.reset_at_target & (value_q >= target_i);

   always_ff @(posedge sys_clk or posedge rst) begin
      if (rst) begin
         value_q <= '0;
      end else if (mode_write_i) begin
         value_q <= '0;
      end else if (value_load_i) begin
         if (ben_i[0]) value_q[7:0] <= wdata_i[7:0];
         if (ben_i[1]) value_q[15:8] <= wdata_i[15:8];
      end else if (count_en) begin
         if (wrap_at_target) begin
            value_q <= '0;
         end else if (!stopped) begin
            // FFFFh rolls over to 0
            value_q <= value_q + 1'b1;
         end
      end
   end

   // hits look at the value before this tick's update
   assign hit_target_o = count_en & (value_q == target_i);
   assign hit_max_o    = count_en & (value_q == root_counter_pkg::COUNT_MAX);

   assign value_o = value_q;

endmodule

// ==== rtl/root_counter_irq.sv ====
`timescale 1ns/1ps

module root_counter_irq (
   input  logic                         sys_clk,
   input  logic                         rst,
   input  logic                         mode_write_i,
   input  logic                         status_clr_i,
   input  root_counter_pkg::mode_word_u mode_i,
   input  logic                         hit_target_i,
   input  logic                         hit_max_i,
   output logic                         irq_n_o,
   output logic                         reached_target_o,
   output logic                         reached_max_o
);

   logic                                 irq_n_q;
   logic                                 fired_q;
   logic [root_counter_pkg::PULSE_W-1:0] pulse_cnt_q;
   logic                                 reached_target_q;
   logic                                 reached_max_q;
   logic                                 irq_event;
   logic                                 accept;
   logic                                 pulse_active;
   logic                                 pulse_done;

   // only enabled hits raise an interrupt
   assign irq_event = (hit_target_i & mode_i.f.irq_on_target) |
                      (hit_max_i & mode_i.f.irq_on_max);

   // pulse mode holds irq_n low while the timer runs
   assign pulse_active = ~mode_i.f.irq_toggle & ~irq_n_q;
   assign pulse_done   = pulse_active & (pulse_cnt_q == '1);

   // repeat pulse waits for the pulse to end, repeat toggle takes every event
   // one-shot takes the first event after a mode write
   assign accept = irq_event &
                   (mode_i.f.irq_repeat ? (mode_i.f.irq_toggle | irq_n_q) : ~fired_q);

   always_ff @(posedge sys_clk or posedge rst) begin
      if (rst) begin
         irq_n_q     <= 1'b1;
         fired_q     <= 1'b0;
         pulse_cnt_q <= '0;
      end else if (mode_write_i) begin
         irq_n_q     <= 1'b1;
         fired_q     <= 1'b0;
         pulse_cnt_q <= '0;
      end else begin
         if (accept) begin
            irq_n_q <= mode_i.f.irq_toggle ? ~irq_n_q : 1'b0;
            fired_q <= 1'b1;
         end else if (pulse_done) begin
            irq_n_q <= 1'b1;
         end
         // counts 0 to 15 across the low pulse
         if (pulse_active && !pulse_done) begin
            pulse_cnt_q <= pulse_cnt_q + 1'b1;
         end else begin
            pulse_cnt_q <= '0;
         end
      end
   end

   // sticky status, a mode read wins over a new hit
   always_ff @(posedge sys_clk or posedge rst) begin
      if (rst) begin
         reached_target_q <= 1'b0;
         reached_max_q    <= 1'b0;
      end else if (status_clr_i) begin
         reached_target_q <= 1'b0;
         reached_max_q    <= 1'b0;
      end else begin
         if (hit_target_i) reached_target_q <= 1'b1;
         if (hit_max_i) reached_max_q <= 1'b1;
      end
   end

   assign irq_n_o          = irq_n_q;
   assign reached_target_o = reached_target_q;
   assign reached_max_o    = reached_max_q;

endmodule

// ==== rtl/root_counter.sv ====
`timescale 1ns/1ps

module root_counter (
   input  logic                               sys_clk,
   input  logic                               rst,
   input  logic                               req_i,
   input  logic                               we_i,
   input  logic [root_counter_pkg::ADDR_W-1:0] addr_i,
   input  root_counter_pkg::word_t            wdata_i,
   input  logic [root_counter_pkg::BEN_W-1:0]  ben_i,
   output logic                               ack_o,
   output root_counter_pkg::word_t            rdata_o,
   output logic                               irq_n_o
);

   logic                               value_load;
   root_counter_pkg::word_t            wdata;
   logic [root_counter_pkg::BEN_W-1:0] ben;
   logic                               mode_write;
   logic                               status_clr;
   root_counter_pkg::word_t            target;
   root_counter_pkg::mode_word_u       mode;
   root_counter_pkg::word_t            value;
   logic                               hit_target;
   logic                               hit_max;
   logic                               irq_n;
   logic                               reached_target;
   logic                               reached_max;

   // host port and registers
   root_counter_regs regs_inst (
      .sys_clk          (sys_clk),
      .rst              (rst),
      .req_i            (req_i),
      .we_i             (we_i),
      .addr_i           (addr_i),
      .wdata_i          (wdata_i),
      .ben_i            (ben_i),
      .value_i          (value),
      .irq_n_i          (irq_n),
      .reached_target_i (reached_target),
      .reached_max_i    (reached_max),
      .ack_o            (ack_o),
      .rdata_o          (rdata_o),
      .value_load_o     (value_load),
      .wdata_o          (wdata),
      .ben_o            (ben),
      .mode_write_o     (mode_write),
      .status_clr_o     (status_clr),
      .target_o         (target),
      .mode_o           (mode)
   );

   root_counter_core core_inst (
      .sys_clk      (sys_clk),
      .rst          (rst),
      .value_load_i (value_load),
      .wdata_i      (wdata),
      .ben_i        (ben),
      .mode_write_i (mode_write),
      .mode_i       (mode),
      .target_i     (target),
      .value_o      (value),
      .hit_target_o (hit_target),
      .hit_max_o    (hit_max)
   );

   // interrupt and sticky status
   root_counter_irq irq_inst (
      .sys_clk          (sys_clk),
      .rst              (rst),
      .mode_write_i     (mode_write),
      .status_clr_i     (status_clr),
      .mode_i           (mode),
      .hit_target_i     (hit_target),
      .hit_max_i        (hit_max),
      .irq_n_o          (irq_n),
      .reached_target_o (reached_target),
      .reached_max_o    (reached_max)
   );

   assign irq_n_o = irq_n;

endmodule

// ==== verif/root_counter_tasks.svh ====
// wrong value, stop at once
task automatic value_error(string what, string detail);
   error_count++;
   $display("[FAIL] %0t: %s, %s", $time, what, detail);
   $display("Finished with errors");
   $fatal(1, "stopped at the first mismatch");
endtask

// protocol or wait failure
task automatic stop_run(string why);
   error_count++;
   $display("%s", why);
   $display("Finished with errors");
   $fatal(1, "stopped on a protocol failure");
endtask

task automatic check_word(string what, root_counter_pkg::word_t got,
                          root_counter_pkg::word_t exp);
   if (got !== exp) begin
      value_error(what, $sformatf("got %04h expected %04h", got, exp));
   end
endtask

// only the fields under mask are compared
task automatic check_mode(string what, root_counter_pkg::mode_word_u got,
                          root_counter_pkg::mode_word_u exp, root_counter_pkg::word_t mask);
   if ((got.raw & mask) !== (exp.raw & mask)) begin
      value_error(what, $sformatf("got %04h expected %04h under mask %04h",
                                  got.raw, exp.raw, mask));
   end
endtask

task automatic check_bit(string what, logic got, logic exp);
   if (got !== exp) begin
      value_error(what, $sformatf("got %0b expected %0b", got, exp));
   end
endtask

// four-phase access, ack answers each edge of req within two cycles
task automatic bus_access(logic write, logic [root_counter_pkg::ADDR_W-1:0] a,
                          root_counter_pkg::word_t d, logic [1:0] b,
                          output root_counter_pkg::word_t q);
   int n;
   @(negedge sys_clk);
   req   = 1'b1;
   we    = write;
   addr  = a;
   wdata = d;
   ben   = b;
   n = 1;
   @(negedge sys_clk);
   while (!ack) begin
      if (n >= 2) begin
         stop_run("ack_o did not rise within two cycles of req_i");
      end
      n++;
      @(negedge sys_clk);
   end
   q   = rdata;
   req = 1'b0;
   n = 1;
   @(negedge sys_clk);
   while (ack) begin
      if (n >= 2) begin
         stop_run("ack_o did not fall within two cycles of req_i dropping");
      end
      n++;
      @(negedge sys_clk);
   end
endtask

task automatic bus_write(logic [root_counter_pkg::ADDR_W-1:0] a,
                         root_counter_pkg::word_t d, logic [1:0] b);
   root_counter_pkg::word_t unused_q;
   bus_access(1'b1, a, d, b, unused_q);
endtask

task automatic bus_read(logic [root_counter_pkg::ADDR_W-1:0] a,
                        output root_counter_pkg::word_t q);
   bus_access(1'b0, a, '0, 2'b00, q);
endtask

// irq_n_o sampled on falling edges
task automatic wait_irq(logic level, int limit);
   int n;
   n = 0;
   while (irq_n !== level) begin
      if (n >= limit) begin
         stop_run($sformatf("irq_n_o did not reach %0b within %0d cycles", level, limit));
      end
      @(negedge sys_clk);
      n++;
   end
endtask

task automatic time_level(logic level, int limit, output int n);
   n = 0;
   while (irq_n === level) begin
      if (n >= limit) begin
         stop_run($sformatf("irq_n_o stayed at %0b for over %0d cycles", level, limit));
      end
      @(negedge sys_clk);
      n++;
   end
endtask

task automatic hold_irq(logic level, int ncycles);
   for (int i = 0; i < ncycles; i++) begin
      check_bit("irq_n_o holds its level", irq_n, level);
      @(negedge sys_clk);
   end
endtask

// cycles between two level changes of irq_n_o
task automatic measure_gap(int limit, output int gap);
   logic level;
   level = irq_n;
   wait_irq(~level, limit);
   time_level(~level, limit, gap);
endtask

task automatic reset_state_test();
   root_counter_pkg::mode_word_u exp_m;
   root_counter_pkg::word_t      q;
   root_counter_pkg::word_t      q2;
   check_bit("ack_o after reset", ack, 1'b0);
   check_bit("irq_n_o after reset", irq_n, 1'b1);
   bus_read(root_counter_pkg::ADDR_TARGET, q);
   check_word("target after reset", q, 16'h0000);
   // target 0 is hit on the first tick after reset
   exp_m.raw              = '0;
   exp_m.f.irq_n          = 1'b1;
   exp_m.f.reached_target = 1'b1;
   bus_read(root_counter_pkg::ADDR_MODE, q);
   check_mode("mode after reset", q, exp_m, 16'hffff);
   // mode 0 is free run on every cycle
   bus_read(root_counter_pkg::ADDR_VALUE, q);
   bus_read(root_counter_pkg::ADDR_VALUE, q2);
   check_bit("value counts up from reset", q2 > q, 1'b1);
endtask

task automatic byte_enable_test();
   root_counter_pkg::word_t exp_t;
   root_counter_pkg::word_t d;
   root_counter_pkg::word_t q;
   exp_t = '0;
   for (int b = 0; b < 4; b++) begin
      d = rand_word(16);
      bus_write(root_counter_pkg::ADDR_TARGET, d, b[1:0]);
      if (b[0]) exp_t[7:0] = d[7:0];
      if (b[1]) exp_t[15:8] = d[15:8];
      bus_read(root_counter_pkg::ADDR_TARGET, q);
      check_word("target after byte enabled write", q, exp_t);
   end
endtask

task automatic target_reset_test();
   root_counter_pkg::mode_word_u m;
   root_counter_pkg::word_t      tgt;
   root_counter_pkg::word_t      q;
   int                           polls;
   tgt = 16'd16 + (rand_word(8) % 16'd185);
   m.raw               = '0;
   m.f.reset_at_target = 1'b1;
   bus_write(root_counter_pkg::ADDR_TARGET, tgt, 2'b11);
   bus_write(root_counter_pkg::ADDR_MODE, m.raw, 2'b11);
   // start from clear status
   bus_read(root_counter_pkg::ADDR_MODE, q);
   repeat (10) begin
      bus_read(root_counter_pkg::ADDR_VALUE, q);
      check_bit("value stays at or below target", q <= tgt, 1'b1);
   end
   repeat (int'(tgt) + 2) @(negedge sys_clk);
   // catch the count early in its period so no hit falls between the mode reads
   polls = 0;
   bus_read(root_counter_pkg::ADDR_VALUE, q);
   while (q > tgt - 16'd12) begin
      polls++;
      if (polls > 100) begin
         stop_run("value never came back near zero under reset at target");
      end
      bus_read(root_counter_pkg::ADDR_VALUE, q);
   end
   m.f.irq_n          = 1'b1;
   m.f.reached_target = 1'b1;
   bus_read(root_counter_pkg::ADDR_MODE, q);
   check_mode("reached target after a period", q, m, 16'h0fff);
   m.f.reached_target = 1'b0;
   bus_read(root_counter_pkg::ADDR_MODE, q);
   check_mode("reached target cleared by mode read", q, m, 16'h0fff);
endtask

task automatic overflow_stop_test();
   root_counter_pkg::mode_word_u m;
   root_counter_pkg::word_t      q;
   m.raw = '0;
   bus_write(root_counter_pkg::ADDR_MODE, m.raw, 2'b11);
   bus_read(root_counter_pkg::ADDR_MODE, q);
   bus_write(root_counter_pkg::ADDR_VALUE, 16'hfff0, 2'b11);
   repeat (40) @(negedge sys_clk);
   bus_read(root_counter_pkg::ADDR_VALUE, q);
   check_bit("value wrapped past FFFFh", q < 16'd40, 1'b1);
   m.f.reached_max = 1'b1;
   bus_read(root_counter_pkg::ADDR_MODE, q);
   check_mode("reached max after wrap", q, m, 16'h1000);
   // sync mode 0 stops the count
   m.raw       = '0;
   m.f.sync_en = 1'b1;
   bus_write(root_counter_pkg::ADDR_MODE, m.raw, 2'b11);
   repeat (3) begin
      bus_read(root_counter_pkg::ADDR_VALUE, q);
      check_word("value held by sync stop", q, 16'h0000);
      repeat (20) @(negedge sys_clk);
   end
endtask

task automatic pulse_irq_test();
   root_counter_pkg::mode_word_u m;
   int                           period;
   int                           n;
   // hits come every target + 1 ticks
   period = 21;
   m.raw               = '0;
   m.f.reset_at_target = 1'b1;
   m.f.irq_on_target   = 1'b1;
   m.f.irq_repeat      = 1'b1;
   bus_write(root_counter_pkg::ADDR_TARGET, 16'd20, 2'b11);
   bus_write(root_counter_pkg::ADDR_MODE, m.raw, 2'b11);
   wait_irq(1'b0, period + 4);
   time_level(1'b0, 40, n);
   check_word("repeat pulse length", root_counter_pkg::word_t'(n), 16'd16);
   wait_irq(1'b0, period);
   time_level(1'b0, 40, n);
   check_word("second repeat pulse length", root_counter_pkg::word_t'(n), 16'd16);
   // one-shot fires once after the mode write
   m.f.irq_repeat = 1'b0;
   bus_write(root_counter_pkg::ADDR_MODE, m.raw, 2'b11);
   wait_irq(1'b0, period + 4);
   time_level(1'b0, 40, n);
   check_word("one-shot pulse length", root_counter_pkg::word_t'(n), 16'd16);
   hold_irq(1'b1, 3 * period);
endtask

task automatic toggle_irq_test();
   root_counter_pkg::mode_word_u m;
   int                           period;
   int                           gap;
   period = 21;
   m.raw               = '0;
   m.f.reset_at_target = 1'b1;
   m.f.irq_on_target   = 1'b1;
   m.f.irq_repeat      = 1'b1;
   m.f.irq_toggle      = 1'b1;
   bus_write(root_counter_pkg::ADDR_MODE, m.raw, 2'b11);
   repeat (2) begin
      measure_gap(period + 4, gap);
      check_word("repeat toggle gap", root_counter_pkg::word_t'(gap), 16'd21);
   end
   m.f.irq_repeat = 1'b0;
   bus_write(root_counter_pkg::ADDR_MODE, m.raw, 2'b11);
   wait_irq(1'b0, period + 4);
   hold_irq(1'b0, 3 * period);
   // eighth-rate tick stretches the period by eight
   m.f.irq_repeat = 1'b1;
   m.f.clk_src    = 2'd1;
   bus_write(root_counter_pkg::ADDR_MODE, m.raw, 2'b11);
   measure_gap(8 * period + 16, gap);
   check_bit("slow toggle gap within 8 cycles of 168",
             (gap >= 8 * period - 8) && (gap <= 8 * period + 8), 1'b1);
endtask

// ==== verif/root_counter_tb.sv ====
`timescale 1ns/1ps

module root_counter_tb;

   // the tests take about 1600 cycles, so this leaves a wide margin
   localparam int TIMEOUT_CYCLES = 20000;

   logic                                sys_clk;
   logic                                rst;
   logic                                req;
   logic                                we;
   logic [root_counter_pkg::ADDR_W-1:0] addr;
   root_counter_pkg::word_t             wdata;
   logic [root_counter_pkg::BEN_W-1:0]  ben;
   logic                                ack;
   root_counter_pkg::word_t             rdata;
   logic                                irq_n;

   logic [31:0] lfsr_q;
   int          cycles = 0;
   int          error_count = 0;

   root_counter root_counter_inst (
      .sys_clk (sys_clk),
      .rst     (rst),
      .req_i   (req),
      .we_i    (we),
      .addr_i  (addr),
      .wdata_i (wdata),
      .ben_i   (ben),
      .ack_o   (ack),
      .rdata_o (rdata),
      .irq_n_o (irq_n)
   );

   initial begin
      sys_clk = 1'b0;
      forever #10 sys_clk = ~sys_clk;
   end

   // run limit
   always @(posedge sys_clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Finished with errors");
         $fatal(1, "simulation stopped by the cycle limit");
      end
   end

   // 32-bit fibonacci lfsr, taps 32 22 2 1
   function automatic logic lfsr_bit();
      logic fb;
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      return fb;
   endfunction

   // one lfsr step per bit taken
   function automatic root_counter_pkg::word_t rand_word(int nbits);
      root_counter_pkg::word_t w;
      w = '0;
      for (int i = 0; i < nbits; i++) begin
         w = {w[14:0], lfsr_bit()};
      end
      return w;
   endfunction

   `include "root_counter_tasks.svh"

   initial begin
      lfsr_q = 32'hfd195435;
      rst    = 1'b1;
      req    = 1'b0;
      we     = 1'b0;
      addr   = '0;
      wdata  = '0;
      ben    = '0;
      repeat (10) @(posedge sys_clk);
      @(negedge sys_clk);
      rst = 1'b0;

      reset_state_test();
      byte_enable_test();
      target_reset_test();
      overflow_stop_test();
      pulse_irq_test();
      toggle_irq_test();

      if (error_count == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== root_counter.f ====
+incdir+verif
rtl/root_counter_pkg.sv
rtl/root_counter_regs.sv
rtl/root_counter_core.sv
rtl/root_counter_irq.sv
rtl/root_counter.sv
verif/root_counter_tb.sv

// ==== Makefile ====
TOP = root_counter_tb

.PHONY: all lint clean

all:
	verilator --binary --timing -j 0 --top-module $(TOP) -f root_counter.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Finished with no errors"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f root_counter.f

clean:
	rm -rf obj_dir
